//--- Bender.yml
package:
  name: acc_cpu

sources:
  - files:
      - rtl/acc_cpu_pkg.sv
      - rtl/acc_alu.sv
      - rtl/main_memory.sv
      - rtl/cpu_control.sv
      - rtl/acc_cpu_top.sv
  - target: test
    files:
      - test/tb_acc_cpu.sv

//--- flist.f
rtl/acc_cpu_pkg.sv
rtl/acc_alu.sv
rtl/main_memory.sv
rtl/cpu_control.sv
rtl/acc_cpu_top.sv
test/tb_acc_cpu.sv

//--- rtl/acc_alu.sv
`timescale 1ns/10ps

module acc_alu (
    input  acc_cpu_pkg::alu_op_t operation,
    input  acc_cpu_pkg::word_t   operand_a,
    input  acc_cpu_pkg::word_t   operand_b,
    output acc_cpu_pkg::word_t   result
);

    // full width product, only the low word is kept
    logic [2*acc_cpu_pkg::word_width-1:0] product;
    // quotient with the zero divisor case folded in
    acc_cpu_pkg::word_t                   quotient;

    assign product = operand_a * operand_b;

    always_comb begin
        if (operand_b == '0) begin
            // no trap on divide by zero
            quotient = '1;
        end else begin
            quotient = operand_a / operand_b;
        end
    end

    always_comb begin
        case (operation)
            acc_cpu_pkg::alu_add: begin
                result = operand_a + operand_b;
            end
            acc_cpu_pkg::alu_sub: begin
                // wraps on underflow
                result = operand_a - operand_b;
            end
            acc_cpu_pkg::alu_mul: begin
                result = product[acc_cpu_pkg::word_width-1:0];
            end
            acc_cpu_pkg::alu_div: begin
                result = quotient;
            end
            // shifts and rotates ignore operand_b
            acc_cpu_pkg::alu_shl: begin
                result = {operand_a[14:0], 1'b0};
            end
            acc_cpu_pkg::alu_shr: begin
                result = {1'b0, operand_a[15:1]};
            end
            acc_cpu_pkg::alu_rol: begin
                result = {operand_a[14:0], operand_a[15]};
            end
            acc_cpu_pkg::alu_ror: begin
                result = {operand_a[0], operand_a[15:1]};
            end
            acc_cpu_pkg::alu_and: begin
                result = operand_a & operand_b;
            end
            acc_cpu_pkg::alu_or: begin
                result = operand_a | operand_b;
            end
            acc_cpu_pkg::alu_xor: begin
                result = operand_a ^ operand_b;
            end
            acc_cpu_pkg::alu_nor: begin
                result = ~(operand_a | operand_b);
            end
            acc_cpu_pkg::alu_nand: begin
                result = ~(operand_a & operand_b);
            end
            acc_cpu_pkg::alu_xnor: begin
                result = ~(operand_a ^ operand_b);
            end
            // compares give one or zero
            acc_cpu_pkg::alu_gt: begin
                result = {15'd0, operand_a > operand_b};
            end
            acc_cpu_pkg::alu_eq: begin
                result = {15'd0, operand_a == operand_b};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- rtl/acc_cpu_pkg.sv
package acc_cpu_pkg;

    // datapath and address widths
    localparam int word_width = 16;
    localparam int addr_width = 8;
    localparam int op_width   = 4;
    localparam int kind_width = 4;

    // one word per address, full address space
    localparam int mem_words = 2 ** addr_width;

    // data and instruction word
    typedef logic [word_width-1:0] word_t;

    // main memory address
    typedef logic [addr_width-1:0] addr_t;

    // alu operation select
    typedef logic [op_width-1:0] alu_op_t;

    // alu operation codes, ordering kept from the original alu
    localparam alu_op_t alu_add  = 4'h0;
    localparam alu_op_t alu_sub  = 4'h1;
    // low half of the product only
    localparam alu_op_t alu_mul  = 4'h2;
    // divide by zero returns all ones
    localparam alu_op_t alu_div  = 4'h3;
    localparam alu_op_t alu_shl  = 4'h4;
    localparam alu_op_t alu_shr  = 4'h5;
    localparam alu_op_t alu_rol  = 4'h6;
    localparam alu_op_t alu_ror  = 4'h7;
    localparam alu_op_t alu_and  = 4'h8;
    localparam alu_op_t alu_or   = 4'h9;
    localparam alu_op_t alu_xor  = 4'ha;
    localparam alu_op_t alu_nor  = 4'hb;
    localparam alu_op_t alu_nand = 4'hc;
    localparam alu_op_t alu_xnor = 4'hd;
    // unsigned compare, result in bit 0
    localparam alu_op_t alu_gt   = 4'he;
    localparam alu_op_t alu_eq   = 4'hf;

    // instruction kind, top nibble of the word
    // codes outside this list behave as halt
    typedef enum logic [kind_width-1:0] {
        kind_halt  = 4'h0,
        kind_load  = 4'h1,
        kind_store = 4'h2,
        kind_alu   = 4'h3,
        kind_jump  = 4'h4,
        kind_jz    = 4'h5
    } kind_t;

    // instruction word split into its fields
    typedef struct packed {
        kind_t   kind;
        alu_op_t op;
        addr_t   addr;
    } instr_t;

    // control sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_exec_read,
        st_exec_wait,
        st_write_back
    } seq_state_t;

endpackage

//--- rtl/acc_cpu_top.sv
`timescale 1ns/10ps

module acc_cpu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic               host_we,
    input  acc_cpu_pkg::addr_t host_addr,
    input  acc_cpu_pkg::word_t host_wdata,
    output acc_cpu_pkg::word_t host_rdata,
    output logic               busy,
    output logic               halted,
    output acc_cpu_pkg::word_t acc,
    output acc_cpu_pkg::addr_t pc
);

    // processor side of the memory
    acc_cpu_pkg::addr_t   mem_addr;
    acc_cpu_pkg::word_t   mem_wdata;
    acc_cpu_pkg::word_t   mem_rdata;
    logic                 mem_we;

    // alu hookup
    acc_cpu_pkg::alu_op_t alu_operation;
    acc_cpu_pkg::word_t   alu_operand_a;
    acc_cpu_pkg::word_t   alu_operand_b;
    acc_cpu_pkg::word_t   alu_result;

    // sequencer and registers
    cpu_control u_control (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .mem_rdata     (mem_rdata),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_we        (mem_we),
        .alu_operation (alu_operation),
        .alu_operand_a (alu_operand_a),
        .alu_operand_b (alu_operand_b),
        .busy          (busy),
        .halted        (halted),
        .acc           (acc),
        .pc            (pc)
    );

    acc_alu u_alu (
        .operation (alu_operation),
        .operand_a (alu_operand_a),
        .operand_b (alu_operand_b),
        .result    (alu_result)
    );

    // busy hands the single port to the processor
    main_memory u_memory (
        .clk        (clk),
        .busy       (busy),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .cpu_we     (mem_we),
        .cpu_addr   (mem_addr),
        .cpu_wdata  (mem_wdata),
        .rdata      (mem_rdata)
    );

    // host sees whatever the port last read
    assign host_rdata = mem_rdata;

endmodule

//--- rtl/cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  acc_cpu_pkg::word_t   mem_rdata,
    input  acc_cpu_pkg::word_t   alu_result,
    output acc_cpu_pkg::addr_t   mem_addr,
    output acc_cpu_pkg::word_t   mem_wdata,
    output logic                 mem_we,
    output acc_cpu_pkg::alu_op_t alu_operation,
    output acc_cpu_pkg::word_t   alu_operand_a,
    output acc_cpu_pkg::word_t   alu_operand_b,
    output logic                 busy,
    output logic                 halted,
    output acc_cpu_pkg::word_t   acc,
    output acc_cpu_pkg::addr_t   pc
);

    // sequencer state
    acc_cpu_pkg::seq_state_t state;

    // instruction register
    acc_cpu_pkg::instr_t ir;
    // memory address and buffer registers
    acc_cpu_pkg::addr_t  mar;
    acc_cpu_pkg::word_t  mbr;

    // memory word seen as an instruction, valid in decode
    acc_cpu_pkg::instr_t fetched;
    // next sequential instruction address, wraps at the top
    acc_cpu_pkg::addr_t  pc_next;
    logic                acc_zero;
    // operand access phase, memory addressed through mar
    logic                exec_phase;

    assign fetched  = acc_cpu_pkg::instr_t'(mem_rdata);
    assign pc_next  = pc + acc_cpu_pkg::addr_t'(1);
    assign acc_zero = (acc == '0);

    assign exec_phase = state inside {acc_cpu_pkg::st_exec_read,
                                      acc_cpu_pkg::st_exec_wait,
                                      acc_cpu_pkg::st_write_back};

    // pc during fetch and decode, operand address afterwards
    assign mem_addr  = exec_phase ? mar : pc;
    // only store writes, always the accumulator
    assign mem_wdata = acc;
    assign mem_we    = (state == acc_cpu_pkg::st_write_back)
                       && (ir.kind == acc_cpu_pkg::kind_store);

    // alu always sees acc against the fetched operand
    assign alu_operation = ir.op;
    assign alu_operand_a = acc;
    assign alu_operand_b = mbr;

    // running whenever the sequencer has left idle
    assign busy = (state != acc_cpu_pkg::st_idle);

    // sequencer, pc, acc and halted flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= acc_cpu_pkg::st_idle;
            halted <= 1'b0;
            pc     <= '0;
            acc    <= '0;
        end else begin
            case (state)
                acc_cpu_pkg::st_idle: begin
                    // acc deliberately survives a restart
                    if (start) begin
                        state  <= acc_cpu_pkg::st_fetch;
                        halted <= 1'b0;
                        pc     <= '0;
                    end
                end
                acc_cpu_pkg::st_fetch: begin
                    // pc on the address bus
                    state <= acc_cpu_pkg::st_fetch_wait;
                end
                acc_cpu_pkg::st_fetch_wait: begin
                    // memory read in flight
                    state <= acc_cpu_pkg::st_decode;
                end
                acc_cpu_pkg::st_decode: begin
                    case (fetched.kind)
                        acc_cpu_pkg::kind_load,
                        acc_cpu_pkg::kind_alu: begin
                            // operand read needed
                            pc    <= pc_next;
                            state <= acc_cpu_pkg::st_exec_read;
                        end
                        acc_cpu_pkg::kind_store: begin
                            // straight to the write cycle
                            pc    <= pc_next;
                            state <= acc_cpu_pkg::st_write_back;
                        end
                        acc_cpu_pkg::kind_jump: begin
                            pc    <= fetched.addr;
                            state <= acc_cpu_pkg::st_fetch;
                        end
                        acc_cpu_pkg::kind_jz: begin
                            if (acc_zero) begin
                                pc <= fetched.addr;
                            end else begin
                                pc <= pc_next;
                            end
                            state <= acc_cpu_pkg::st_fetch;
                        end
                        default: begin
                            // halt and unknown kinds, pc stays on this word
                            // busy drops in the same cycle halted rises
                            state  <= acc_cpu_pkg::st_idle;
                            halted <= 1'b1;
                        end
                    endcase
                end
                acc_cpu_pkg::st_exec_read: begin
                    // mar on the address bus
                    state <= acc_cpu_pkg::st_exec_wait;
                end
                acc_cpu_pkg::st_exec_wait: begin
                    // operand lands in mbr this cycle
                    state <= acc_cpu_pkg::st_write_back;
                end
                acc_cpu_pkg::st_write_back: begin
                    if (ir.kind == acc_cpu_pkg::kind_load) begin
                        acc <= mbr;
                    end else if (ir.kind == acc_cpu_pkg::kind_alu) begin
                        acc <= alu_result;
                    end
                    // store needs nothing here, mem_we covers it
                    state <= acc_cpu_pkg::st_fetch;
                end
                default: begin
                    state <= acc_cpu_pkg::st_idle;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        // latch instruction and operand address
        if (state == acc_cpu_pkg::st_decode) begin
            ir  <= fetched;
            mar <= fetched.addr;
        end
        // operand word from memory
        if (state == acc_cpu_pkg::st_exec_wait) begin
            mbr <= mem_rdata;
        end
    end

endmodule

//--- rtl/main_memory.sv
`timescale 1ns/10ps

module main_memory (
    input  logic               clk,
    input  logic               busy,
    input  logic               host_we,
    input  acc_cpu_pkg::addr_t host_addr,
    input  acc_cpu_pkg::word_t host_wdata,
    input  logic               cpu_we,
    input  acc_cpu_pkg::addr_t cpu_addr,
    input  acc_cpu_pkg::word_t cpu_wdata,
    output acc_cpu_pkg::word_t rdata
);

    // storage array, contents undefined until written
    acc_cpu_pkg::word_t ram [acc_cpu_pkg::mem_words];

    // selected port side
    logic               sel_we;
    acc_cpu_pkg::addr_t sel_addr;
    acc_cpu_pkg::word_t sel_wdata;

    // processor owns the port while running
    // host strobe dropped entirely when busy
    assign sel_we    = busy ? cpu_we    : host_we;
    assign sel_addr  = busy ? cpu_addr  : host_addr;
    assign sel_wdata = busy ? cpu_wdata : host_wdata;

    // single port, write has priority over read
    // read data appears the cycle after the address
    always_ff @(posedge clk) begin
        if (sel_we) begin
            ram[sel_addr] <= sel_wdata;
        end else begin
            // rdata holds its value during a write
            rdata <= ram[sel_addr];
        end
    end

endmodule

//--- test/tb_acc_cpu.sv
`timescale 1ns/10ps

module tb_acc_cpu;

    // cycles allowed for one program run
    localparam int halt_timeout = 2000;

    logic                     clk;
    logic                     arst_n;
    logic                     start;
    logic                     host_we;
    acc_cpu_pkg::addr_t       host_addr;
    acc_cpu_pkg::word_t       host_wdata;
    acc_cpu_pkg::word_t       host_rdata;
    logic                     busy;
    logic                     halted;
    acc_cpu_pkg::word_t       acc;
    acc_cpu_pkg::addr_t       pc;

    // galois lfsr state
    logic [31:0]              lfsr_state;
    // expected memory contents for the host sweep
    acc_cpu_pkg::word_t       shadow [acc_cpu_pkg::mem_words];

    acc_cpu_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .busy       (busy),
        .halted     (halted),
        .acc        (acc),
        .pc         (pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one lfsr step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic acc_cpu_pkg::word_t rand_word();
        acc_cpu_pkg::word_t w;
        for (int i = 0; i < 16; i++) begin
            w = {w[14:0], lfsr_bit()};
        end
        return w;
    endfunction

    // pack one instruction word
    function automatic acc_cpu_pkg::word_t assemble(acc_cpu_pkg::kind_t kind,
                                                   acc_cpu_pkg::alu_op_t op,
                                                   acc_cpu_pkg::addr_t addr);
        acc_cpu_pkg::instr_t ins;
        ins.kind = kind;
        ins.op   = op;
        ins.addr = addr;
        return acc_cpu_pkg::word_t'(ins);
    endfunction

    // expected alu result from the operation table
    function automatic acc_cpu_pkg::word_t alu_model(acc_cpu_pkg::alu_op_t op,
                                                    acc_cpu_pkg::word_t a,
                                                    acc_cpu_pkg::word_t b);
        acc_cpu_pkg::word_t r;
        case (op)
            acc_cpu_pkg::alu_add:  r = a + b;
            acc_cpu_pkg::alu_sub:  r = a - b;
            // truncated on assignment
            acc_cpu_pkg::alu_mul:  r = a * b;
            acc_cpu_pkg::alu_div:  r = (b == 16'd0) ? 16'hffff : a / b;
            acc_cpu_pkg::alu_shl:  r = a << 1;
            acc_cpu_pkg::alu_shr:  r = a >> 1;
            acc_cpu_pkg::alu_rol:  r = (a << 1) | (a >> 15);
            acc_cpu_pkg::alu_ror:  r = (a >> 1) | (a << 15);
            acc_cpu_pkg::alu_and:  r = a & b;
            acc_cpu_pkg::alu_or:   r = a | b;
            acc_cpu_pkg::alu_xor:  r = a ^ b;
            acc_cpu_pkg::alu_nor:  r = ~(a | b);
            acc_cpu_pkg::alu_nand: r = ~(a & b);
            acc_cpu_pkg::alu_xnor: r = ~(a ^ b);
            acc_cpu_pkg::alu_gt:   r = (a > b) ? 16'd1 : 16'd0;
            default:               r = (a == b) ? 16'd1 : 16'd0;
        endcase
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // all host tasks start and end 1 ns after a rising edge
    task automatic write_word(input acc_cpu_pkg::addr_t addr, input acc_cpu_pkg::word_t data);
        host_addr  = addr;
        host_wdata = data;
        host_we    = 1'b1;
        @(posedge clk);
        #1;
        host_we = 1'b0;
    endtask

    // data registered at the edge after the address
    task automatic read_word(input acc_cpu_pkg::addr_t addr, output acc_cpu_pkg::word_t data);
        host_addr = addr;
        host_we   = 1'b0;
        @(posedge clk);
        #1;
        data = host_rdata;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("start busy", 1, busy);
        check_value("start halted", 0, halted);
    endtask

    // counts edges until busy falls
    task automatic wait_halt(output int cycles);
        int count;
        count = 0;
        while (busy) begin
            if (count >= halt_timeout) begin
                fail_run("machine never halted within the cycle limit");
            end
            @(posedge clk);
            #1;
            count++;
        end
        cycles = count;
    endtask

    // load a, alu op b, store to 0x82, halt
    task automatic run_alu_program(input string name, input acc_cpu_pkg::alu_op_t op,
                                   input acc_cpu_pkg::word_t a, input acc_cpu_pkg::word_t b);
        acc_cpu_pkg::word_t stored;
        int                 cycles;
        write_word(8'h00, assemble(acc_cpu_pkg::kind_load, 4'h0, 8'h80));
        write_word(8'h01, assemble(acc_cpu_pkg::kind_alu, op, 8'h81));
        write_word(8'h02, assemble(acc_cpu_pkg::kind_store, 4'h0, 8'h82));
        write_word(8'h03, assemble(acc_cpu_pkg::kind_halt, 4'h0, 8'h00));
        write_word(8'h80, a);
        write_word(8'h81, b);
        pulse_start();
        wait_halt(cycles);
        // 6 + 6 + 4 + 3 cycles
        check_value({name, " cycles"}, 19, cycles);
        check_value({name, " acc"}, alu_model(op, a, b), acc);
        check_value({name, " pc"}, 3, pc);
        check_value({name, " halted"}, 1, halted);
        read_word(8'h82, stored);
        check_value({name, " stored"}, alu_model(op, a, b), stored);
    endtask

    task automatic reset_and_memory();
        acc_cpu_pkg::word_t data;
        check_value("reset busy", 0, busy);
        check_value("reset halted", 0, halted);
        check_value("reset acc", 0, acc);
        check_value("reset pc", 0, pc);
        for (int i = 0; i < acc_cpu_pkg::mem_words; i++) begin
            shadow[i] = rand_word();
            write_word(acc_cpu_pkg::addr_t'(i), shadow[i]);
        end
        for (int i = 0; i < acc_cpu_pkg::mem_words; i++) begin
            read_word(acc_cpu_pkg::addr_t'(i), data);
            check_value($sformatf("host memory %0d", i), shadow[i], data);
        end
    endtask

    task automatic alu_sweep();
        acc_cpu_pkg::word_t a;
        acc_cpu_pkg::word_t b;
        for (int i = 0; i < 16; i++) begin
            a = rand_word();
            b = rand_word();
            run_alu_program($sformatf("alu op %0d", i), acc_cpu_pkg::alu_op_t'(i), a, b);
        end
    endtask

    task automatic edge_operands();
        acc_cpu_pkg::word_t a;
        a = rand_word();
        run_alu_program("divide by zero", acc_cpu_pkg::alu_div, a, 16'h0000);
        // top and bottom bits both set
        run_alu_program("shl edge", acc_cpu_pkg::alu_shl, 16'h8001, a);
        run_alu_program("shr edge", acc_cpu_pkg::alu_shr, 16'h8001, a);
        run_alu_program("rol edge", acc_cpu_pkg::alu_rol, 16'h8001, a);
        run_alu_program("ror edge", acc_cpu_pkg::alu_ror, 16'h8001, a);
        run_alu_program("gt equal", acc_cpu_pkg::alu_gt, a, a);
        run_alu_program("eq equal", acc_cpu_pkg::alu_eq, a, a);
    endtask

    // n at 0x90, constant one at 0x91, counter at 0x92
    task automatic countdown_loop();
        acc_cpu_pkg::word_t n;
        acc_cpu_pkg::word_t data;
        int                 cycles;
        n = {12'd0, lfsr_bit(), lfsr_bit(), lfsr_bit(), lfsr_bit()} + 16'd1;
        write_word(8'h00, assemble(acc_cpu_pkg::kind_load, 4'h0, 8'h90));
        write_word(8'h01, assemble(acc_cpu_pkg::kind_jz, 4'h0, 8'h09));
        write_word(8'h02, assemble(acc_cpu_pkg::kind_alu, acc_cpu_pkg::alu_sub, 8'h91));
        write_word(8'h03, assemble(acc_cpu_pkg::kind_store, 4'h0, 8'h90));
        write_word(8'h04, assemble(acc_cpu_pkg::kind_load, 4'h0, 8'h92));
        write_word(8'h05, assemble(acc_cpu_pkg::kind_alu, acc_cpu_pkg::alu_add, 8'h91));
        write_word(8'h06, assemble(acc_cpu_pkg::kind_store, 4'h0, 8'h92));
        write_word(8'h07, assemble(acc_cpu_pkg::kind_load, 4'h0, 8'h90));
        write_word(8'h08, assemble(acc_cpu_pkg::kind_jump, 4'h0, 8'h01));
        write_word(8'h09, assemble(acc_cpu_pkg::kind_halt, 4'h0, 8'h00));
        write_word(8'h90, n);
        write_word(8'h91, 16'd1);
        write_word(8'h92, 16'd0);
        pulse_start();
        wait_halt(cycles);
        check_value("countdown pc", 9, pc);
        check_value("countdown acc", 0, acc);
        check_value("countdown halted", 1, halted);
        read_word(8'h92, data);
        check_value("countdown counter", n, data);
        read_word(8'h90, data);
        check_value("countdown n", 0, data);
    endtask

    task automatic restart_rules();
        acc_cpu_pkg::word_t a;
        acc_cpu_pkg::word_t guard;
        acc_cpu_pkg::word_t data;
        int                 cycles;
        a     = rand_word();
        guard = rand_word();
        write_word(8'ha0, guard);
        run_alu_program("restart first run", acc_cpu_pkg::alu_xor, a, guard);
        // result word overwritten, only a second store restores it
        write_word(8'h82, ~alu_model(acc_cpu_pkg::alu_xor, a, guard));
        // second run with a start pulse and a host write while busy
        pulse_start();
        start      = 1'b1;
        host_we    = 1'b1;
        host_addr  = 8'ha0;
        host_wdata = ~guard;
        @(posedge clk);
        #1;
        start   = 1'b0;
        host_we = 1'b0;
        wait_halt(cycles);
        // one edge already spent on the ignored inputs
        check_value("restart cycles", 19, cycles + 1);
        check_value("restart acc", alu_model(acc_cpu_pkg::alu_xor, a, guard), acc);
        check_value("restart pc", 3, pc);
        check_value("restart halted", 1, halted);
        read_word(8'h82, data);
        check_value("restart stored", alu_model(acc_cpu_pkg::alu_xor, a, guard), data);
        read_word(8'ha0, data);
        check_value("write while busy", guard, data);
    endtask

    initial begin
        lfsr_state = 32'h3fa1_dc46;
        arst_n     = 1'b0;
        start      = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_and_memory();
        alu_sweep();
        edge_operands();
        countdown_loop();
        restart_rules();
        $display("Everything OK");
        $finish;
    end

endmodule
